// ==== build.sh ====
#!/bin/sh
# Compile and run the readback testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rpspmcReadbackTb -Mdir obj_dir \
    -f rpspmcReadback.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VrpspmcReadbackTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== rpspmcReadback.f ====
verilog/rpspmcPkg.sv
verilog/biasSummer.sv
verilog/gvpRamp.sv
verilog/zPlaneSlope.sv
verilog/readbackConfig.sv
verilog/rpspmcReadback.sv
test/rpspmcReadback_asserts.sv
test/rpspmcReadbackTb.sv

// ==== test/rpspmcReadbackTb.sv ====
`default_nettype none

module rpspmcReadbackTb
    import rpspmcPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeoutCycles = 4000;

    logic aclk = 1'b0;
    logic rstN = 1'b0;
    logic [31:0] configAddr = '0;
    logic signed [31:0] biasU0 = '0;
    logic signed [31:0] biasMod = '0;
    logic signed [31:0] adcCh1 = '0;
    logic signed [31:0] adcCh2 = '0;
    logic signed [31:0] xA = '0;
    logic signed [31:0] xB = '0;
    logic signed [31:0] slopeStep = '0;
    logic gvpStart = 1'b0;
    logic sampleStrobe = 1'b0;
    logic gvpBusy;
    gvpCmd_t gvpCmd = '0;
    readbackPair_t readback;

    // Expected state of the accumulators
    logic signed [31:0] expBiasGvp = '0;
    logic signed [31:0] expZGvp = '0;
    logic signed [31:0] expZSlope = '0;
    logic [31:0] lfsrState = 32'hf7e6_4be8;
    int errors = 0;
    int cycleCount = 0;

    rpspmcReadback dut0 (.aclk(aclk), .rstN(rstN), .configAddr(configAddr), .biasU0(biasU0),
        .biasMod(biasMod), .adcCh1(adcCh1), .adcCh2(adcCh2), .xA(xA), .xB(xB),
        .gvpStart(gvpStart), .gvpCmd(gvpCmd), .sampleStrobe(sampleStrobe),
        .slopeStep(slopeStep), .gvpBusy(gvpBusy), .readback(readback));

    always #4 aclk = ~aclk;

    // Hard stop on a hung run
    always @(posedge aclk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutCycles)
        begin
            $display("Timeout: tests still running after %0d cycles", timeoutCycles);
            $display("Some tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Taps 32 22 2 1 with one shift per bit
    function automatic logic [31:0] randWord(input int nBits);
        logic [31:0] result;
        logic fb;
        result = '0;
        for (int i = 0; i < nBits; i++)
        begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            result = {result[30:0], fb};
        end
        return result;
    endfunction

    // Clamp to the signed word rails
    function automatic logic signed [31:0] saturate(input longint value);
        if (value > 64'sd2147483647)
            return 32'sh7fff_ffff;
        if (value < -64'sd2147483648)
            return 32'sh8000_0000;
        return value[31:0];
    endfunction

    task automatic checkWord(input string what, input logic [31:0] expected,
                             input logic [31:0] observed);
        assert (observed === expected)
        else
        begin
            errors++;
            $display("MISMATCH %0t addr=%0d %s expected %0h observed %0h",
                     $time, configAddr, what, expected, observed);
        end
    endtask

    // Select an address, let the pipeline settle, sample mid cycle
    task automatic selectAndSettle(input logic [31:0] addr);
        @(posedge aclk);
        configAddr <= addr;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic testDirect();
        @(posedge aclk);
        adcCh1 <= randWord(32);
        adcCh2 <= randWord(32);
        xA     <= randWord(32);
        xB     <= randWord(32);
        selectAndSettle(addrAdc);
        checkWord("adcCh1", adcCh1, readback.dataA);
        checkWord("adcCh2", adcCh2, readback.dataB);
        selectAndSettle(addrX);
        checkWord("xA", xA, readback.dataA);
        checkWord("xB", xB, readback.dataB);
    endtask

    task automatic testBias();
        logic signed [31:0] u0;
        logic signed [31:0] m;
        for (int i = 0; i < 6; i++)
        begin
            // Rails first, then random words
            u0 = (i == 0) ? 32'sh7fff_ffff : (i == 1) ? 32'sh8000_0000 : randWord(32);
            m  = (i == 0) ? 32'sh7fff_ffff : (i == 1) ? 32'sh8000_0000 : randWord(32);
            @(posedge aclk);
            biasU0  <= u0;
            biasMod <= m;
            selectAndSettle(addrBias);
            checkWord("biasSum", saturate(longint'(u0) + longint'(expBiasGvp) + longint'(m)),
                      readback.dataA);
            checkWord("biasU0", u0, readback.dataB);
        end
    endtask

    task automatic testGvp();
        logic signed [31:0] stepB;
        logic signed [31:0] stepZ;
        int cnt;
        stepB = randWord(32);
        stepZ = randWord(32);
        // At least 3 steps so the second start lands while busy
        cnt = 3 + randWord(5);
        @(posedge aclk);
        gvpCmd   <= '{stepBias: stepB, stepZ: stepZ, count: cnt[15:0]};
        gvpStart <= 1'b1;
        @(posedge aclk);
        gvpStart <= 1'b0;
        @(negedge aclk);
        assert (gvpBusy)
        else
        begin
            errors++;
            $display("Vector program did not go busy after a start at %0t", $time);
        end
        // A start during a run is ignored
        @(posedge aclk);
        gvpCmd   <= '{stepBias: randWord(32), stepZ: randWord(32), count: 16'd50};
        gvpStart <= 1'b1;
        @(posedge aclk);
        gvpStart <= 1'b0;
        @(negedge aclk);
        while (gvpBusy)
            @(negedge aclk);
        expBiasGvp = saturate(longint'(expBiasGvp) + longint'(cnt) * longint'(stepB));
        expZGvp    = saturate(longint'(expZGvp) + longint'(cnt) * longint'(stepZ));
        selectAndSettle(addrGvpBias);
        checkWord("biasGvp", expBiasGvp, readback.dataA);
        checkWord("biasMod", biasMod, readback.dataB);
        selectAndSettle(addrZ);
        checkWord("zGvp", expZGvp, readback.dataA);
        checkWord("zSlope", expZSlope, readback.dataB);
    endtask

    task automatic testSlope();
        logic signed [31:0] step;
        int n;
        step = randWord(32);
        n = 1 + randWord(4);
        @(posedge aclk);
        slopeStep <= step;
        repeat (n)
        begin
            @(posedge aclk);
            sampleStrobe <= 1'b1;
            @(posedge aclk);
            sampleStrobe <= 1'b0;
        end
        expZSlope = saturate(longint'(expZSlope) + longint'(n) * longint'(step));
        selectAndSettle(addrZ);
        checkWord("zSlope", expZSlope, readback.dataB);
    endtask

    task automatic testTiming();
        selectAndSettle(addrTimingReset);
        checkWord("reset A", 32'd0, readback.dataA);
        checkWord("reset B", 32'd0, readback.dataB);
        selectAndSettle(addrTimingTest);
        checkWord("clock A", clockHz, readback.dataA);
        checkWord("clock B", clockHz, readback.dataB);
        // Three counter cycles since the clock constant
        selectAndSettle(32'd12345);
        checkWord("counter A", clockHz + 32'd3, readback.dataA);
        checkWord("counter B", clockHz + 32'd15, readback.dataB);
        @(negedge aclk);
        checkWord("counter A", clockHz + 32'd4, readback.dataA);
        checkWord("counter B", clockHz + 32'd16, readback.dataB);
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial
    begin
        repeat (16) @(posedge aclk);
        rstN <= 1'b1;
        testDirect();
        testBias();
        testGvp();
        // Bias sum again with a nonzero program offset
        testBias();
        testSlope();
        testTiming();
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/rpspmcReadback_asserts.sv ====
`default_nettype none

module rpspmcReadbackAsserts
    import rpspmcPkg::*;
(
    input logic                aclk,
    input logic                rstN,
    input logic [monWidth-1:0] configAddr,
    input readbackPair_t       readback
);

    timeunit 1ns;
    timeprecision 100ps;

    // Address that falls through to the counter mode
    logic defaultAddr;

    assign defaultAddr = !(configAddr inside {addrZ, addrBias, addrGvpBias, addrAdc,
                                              addrX, addrTimingTest, addrTimingReset});

    //////////////////////////////////////////////////
    // Timing aid properties
    //////////////////////////////////////////////////

    // Clear address zeroes the pair
    timingResetClears: assert property (@(posedge aclk) disable iff (!rstN)
        (configAddr == addrTimingReset) |=> (readback == '0))
    else $error("timing reset address did not clear the readback pair");

    // Counter mode keeps B twelve ahead of A
    counterOffset: assert property (@(posedge aclk) disable iff (!rstN)
        defaultAddr |=> (readback.dataB == readback.dataA + 32'sd12))
    else $error("counter mode word B is not word A plus 12");

    // Clock constant in word A
    timingTestClock: assert property (@(posedge aclk) disable iff (!rstN)
        (configAddr == addrTimingTest) |=> (readback.dataA == clockHz))
    else $error("timing test address did not return the clock constant");

endmodule

bind readbackConfig rpspmcReadbackAsserts asserts0 (
    .aclk       (aclk),
    .rstN       (rstN),
    .configAddr (configAddr),
    .readback   (readback)
);

`default_nettype wire

// ==== verilog/biasSummer.sv ====
`default_nettype none

module biasSummer
    import rpspmcPkg::*;
(
    input  logic                       aclk,
    input  logic                       rstN,
    // Bias set value from the host
    input  logic signed [monWidth-1:0] biasU0,
    // Offset from the vector program
    input  logic signed [monWidth-1:0] biasGvp,
    // Modifier input, lock-in and aux
    input  logic signed [monWidth-1:0] biasMod,
    output logic signed [monWidth-1:0] biasSum
);

    //////////////////////////////////////////////////
    // Wide adder
    //////////////////////////////////////////////////

    // Two guard bits cover any sum of three words
    logic signed [monWidth+1:0] wideSum;
    logic signed [monWidth-1:0] clampedSum;

    always_comb
    begin
        // Operands sign extend in the wide context
        wideSum = biasU0 + biasGvp + biasMod;
        // Pin to the rail on overflow
        clampedSum = satClamp(wideSum);
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    // One cycle from inputs to sum
    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            biasSum <= '0;
        end
        else
        begin
            biasSum <= clampedSum;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/gvpRamp.sv ====
`default_nettype none

module gvpRamp
    import rpspmcPkg::*;
(
    input  logic                       aclk,
    input  logic                       rstN,
    // Single-cycle start request
    input  logic                       gvpStart,
    input  gvpCmd_t                    gvpCmd,
    output logic                       gvpBusy,
    output logic signed [monWidth-1:0] biasGvp,
    output logic signed [monWidth-1:0] zGvp
);

    //////////////////////////////////////////////////
    // Latched command and step counter
    //////////////////////////////////////////////////

    logic signed [monWidth-1:0] stepBiasQ;
    logic signed [monWidth-1:0] stepZQ;
    // Steps still to go in this run
    logic [15:0]                stepsLeft;

    // Wide next accumulator values before the clamp
    logic signed [monWidth+1:0] biasWide;
    logic signed [monWidth+1:0] zWide;

    always_comb
    begin
        biasWide = biasGvp + stepBiasQ;
        zWide    = zGvp + stepZQ;
    end

    // Step sizes captured on an accepted start
    always_ff @(posedge aclk)
    begin
        if (gvpStart && !gvpBusy)
        begin
            stepBiasQ <= gvpCmd.stepBias;
            stepZQ    <= gvpCmd.stepZ;
        end
    end

    //////////////////////////////////////////////////
    // Run control and accumulators
    //////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            gvpBusy   <= 1'b0;
            stepsLeft <= '0;
            biasGvp   <= '0;
            zGvp      <= '0;
        end
        else if (!gvpBusy)
        begin
            // Idle state accepts a start and a zero count never goes busy
            if (gvpStart)
            begin
                stepsLeft <= gvpCmd.count;
                gvpBusy   <= (gvpCmd.count != 16'd0);
            end
        end
        else
        begin
            // One step per busy cycle and any start is ignored
            biasGvp   <= satClamp(biasWide);
            zGvp      <= satClamp(zWide);
            stepsLeft <= stepsLeft - 16'd1;
            // Last step drops busy
            if (stepsLeft == 16'd1)
                gvpBusy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/readbackConfig.sv ====
`default_nettype none

module readbackConfig
    import rpspmcPkg::*;
(
    input  logic                aclk,
    input  logic                rstN,
    // Host selected readback address
    input  logic [monWidth-1:0] configAddr,
    input  rbMonitor_t          monitor,
    output readbackPair_t       readback
);

    //////////////////////////////////////////////////
    // Address decode and pair register
    //////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            readback <= '0;
        end
        else
        begin
            case (configAddr)
                // Z program position and plane slope
                addrZ:
                begin
                    readback.dataA <= monitor.zGvp;
                    readback.dataB <= monitor.zSlope;
                end
                // Total bias and its set value
                addrBias:
                begin
                    readback.dataA <= monitor.biasSum;
                    readback.dataB <= monitor.biasU0;
                end
                // Program offset and modifier
                addrGvpBias:
                begin
                    readback.dataA <= monitor.biasGvp;
                    readback.dataB <= monitor.biasMod;
                end
                // External converter channels
                addrAdc:
                begin
                    readback.dataA <= monitor.adcCh1;
                    readback.dataB <= monitor.adcCh2;
                end
                // Auxiliary words
                addrX:
                begin
                    readback.dataA <= monitor.xA;
                    readback.dataB <= monitor.xB;
                end
                // Clear both words
                addrTimingReset:
                begin
                    readback <= '0;
                end
                // Clock constant, previous A into B
                addrTimingTest:
                begin
                    readback.dataA <= clockHz;
                    readback.dataB <= readback.dataA;
                end
                // Free-running counter, B leads new A by 12
                default:
                begin
                    readback.dataA <= readback.dataA + 32'sd1;
                    readback.dataB <= readback.dataA + 32'sd13;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rpspmcPkg.sv ====
`default_nettype none

package rpspmcPkg;

    //////////////////////////////////////////////////
    // Word sizes and constants
    //////////////////////////////////////////////////

    // Width of every monitor and readback word
    localparam int monWidth = 32;

    // Clock frequency reported at the timing test address
    localparam logic signed [monWidth-1:0] clockHz = 32'sd125000000;

    // Clamp limits of a signed word
    localparam logic signed [monWidth-1:0] wordMax = {1'b0, {(monWidth-1){1'b1}}};
    localparam logic signed [monWidth-1:0] wordMin = {1'b1, {(monWidth-1){1'b0}}};

    //////////////////////////////////////////////////
    // Readback addresses
    //////////////////////////////////////////////////

    localparam logic [monWidth-1:0] addrZ           = 32'd100001;
    localparam logic [monWidth-1:0] addrBias        = 32'd100002;
    localparam logic [monWidth-1:0] addrGvpBias     = 32'd100003;
    localparam logic [monWidth-1:0] addrAdc         = 32'd100100;
    localparam logic [monWidth-1:0] addrX           = 32'd100999;
    localparam logic [monWidth-1:0] addrTimingTest  = 32'd101999;
    localparam logic [monWidth-1:0] addrTimingReset = 32'd102000;

    //////////////////////////////////////////////////
    // Shared structs
    //////////////////////////////////////////////////

    // All readback sources, one word each
    typedef struct packed {
        logic signed [monWidth-1:0] zGvp;
        logic signed [monWidth-1:0] zSlope;
        logic signed [monWidth-1:0] biasSum;
        logic signed [monWidth-1:0] biasU0;
        logic signed [monWidth-1:0] biasGvp;
        logic signed [monWidth-1:0] biasMod;
        logic signed [monWidth-1:0] adcCh1;
        logic signed [monWidth-1:0] adcCh2;
        logic signed [monWidth-1:0] xA;
        logic signed [monWidth-1:0] xB;
    } rbMonitor_t;

    // Vector-program settings
    typedef struct packed {
        logic signed [monWidth-1:0] stepBias;
        logic signed [monWidth-1:0] stepZ;
        logic [15:0]                count;
    } gvpCmd_t;

    // Readback result pair
    typedef struct packed {
        logic signed [monWidth-1:0] dataA;
        logic signed [monWidth-1:0] dataB;
    } readbackPair_t;

    // Clamp a two-bit-wider sum back into the word range
    function automatic logic signed [monWidth-1:0] satClamp(
        input logic signed [monWidth+1:0] wide
    );
        logic signed [monWidth-1:0] result;
        if (wide > wordMax)
            result = wordMax;
        else if (wide < wordMin)
            result = wordMin;
        else
            result = wide[monWidth-1:0];
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/rpspmcReadback.sv ====
`default_nettype none

module rpspmcReadback
    import rpspmcPkg::*;
(
    input  logic                       aclk,
    input  logic                       rstN,
    input  logic [monWidth-1:0]        configAddr,
    input  logic signed [monWidth-1:0] biasU0,
    input  logic signed [monWidth-1:0] biasMod,
    input  logic signed [monWidth-1:0] adcCh1,
    input  logic signed [monWidth-1:0] adcCh2,
    input  logic signed [monWidth-1:0] xA,
    input  logic signed [monWidth-1:0] xB,
    input  logic                       gvpStart,
    input  gvpCmd_t                    gvpCmd,
    input  logic                       sampleStrobe,
    input  logic signed [monWidth-1:0] slopeStep,
    output logic                       gvpBusy,
    output readbackPair_t              readback
);

    //////////////////////////////////////////////////
    // Internal monitor values
    //////////////////////////////////////////////////

    logic signed [monWidth-1:0] biasGvp;
    logic signed [monWidth-1:0] zGvp;
    logic signed [monWidth-1:0] zSlope;
    logic signed [monWidth-1:0] biasSum;
    rbMonitor_t                 monitor;

    // Vector program drives both offsets
    gvpRamp gvpRamp0 (
        .aclk     (aclk),
        .rstN     (rstN),
        .gvpStart (gvpStart),
        .gvpCmd   (gvpCmd),
        .gvpBusy  (gvpBusy),
        .biasGvp  (biasGvp),
        .zGvp     (zGvp)
    );

    // Tilt correction
    zPlaneSlope zPlaneSlope0 (
        .aclk         (aclk),
        .rstN         (rstN),
        .sampleStrobe (sampleStrobe),
        .slopeStep    (slopeStep),
        .zSlope       (zSlope)
    );

    // Total bias, one cycle behind its inputs
    biasSummer biasSummer0 (
        .aclk    (aclk),
        .rstN    (rstN),
        .biasU0  (biasU0),
        .biasGvp (biasGvp),
        .biasMod (biasMod),
        .biasSum (biasSum)
    );

    // Gather every source for the readback mux
    assign monitor = '{
        zGvp:    zGvp,
        zSlope:  zSlope,
        biasSum: biasSum,
        biasU0:  biasU0,
        biasGvp: biasGvp,
        biasMod: biasMod,
        adcCh1:  adcCh1,
        adcCh2:  adcCh2,
        xA:      xA,
        xB:      xB
    };

    // Address decoded readback pair
    readbackConfig readbackConfig0 (
        .aclk       (aclk),
        .rstN       (rstN),
        .configAddr (configAddr),
        .monitor    (monitor),
        .readback   (readback)
    );

endmodule

`default_nettype wire

// ==== verilog/zPlaneSlope.sv ====
`default_nettype none

module zPlaneSlope
    import rpspmcPkg::*;
(
    input  logic                       aclk,
    input  logic                       rstN,
    // One pulse per scan sample
    input  logic                       sampleStrobe,
    // Tilt increment per sample
    input  logic signed [monWidth-1:0] slopeStep,
    output logic signed [monWidth-1:0] zSlope
);

    //////////////////////////////////////////////////
    // Slope accumulator
    //////////////////////////////////////////////////

    // Wide next value before the clamp
    logic signed [monWidth+1:0] zSlopeWide;

    always_comb
    begin
        zSlopeWide = zSlope + slopeStep;
    end

    // Correction holds between strobes
    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            zSlope <= '0;
        end
        else if (sampleStrobe)
        begin
            // Saturate so a long scan cannot wrap the tilt
            zSlope <= satClamp(zSlopeWide);
        end
    end

endmodule

`default_nettype wire
